// File: design/ble_pkg.sv
package ble_pkg;

  // Payload widths
  typedef logic [15:0] feature_word_t;
  typedef logic [7:0]  uart_byte_t;
  typedef logic [15:0] param_word_t;

  // One entry of the feature stream
  typedef struct packed {
    feature_word_t data;
    logic          last;
  } feature_beat_t;

  typedef enum logic [2:0] {
    IDLE,
    LOW_BYTE,
    HIGH_BYTE,
    FLUSH,
    DROP
  } tx_state_t;

  // UART timing, kept short for simulation
  localparam int SAMPLE_RATE     = 16;
  localparam int CLKS_PER_TICK   = 2;
  localparam int TICK_DIV_W      = $clog2(CLKS_PER_TICK);
  localparam int TICK_CNT_W      = $clog2(SAMPLE_RATE);
  localparam int UART_DATA_BITS  = 8;
  localparam int UART_FRAME_BITS = UART_DATA_BITS + 2;
  localparam int BIT_CNT_W       = $clog2(UART_FRAME_BITS);

  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

  // Newline, lets the host flush its line buffer
  localparam uart_byte_t FLUSH_BYTE = 8'h0A;

endpackage

// File: design/baud_tick_gen.sv
`timescale 1ns/100ps

module baud_tick_gen (
  input  logic clk_in,
  input  logic rst_in,
  output logic tick
);
  import ble_pkg::*;

  logic [TICK_DIV_W-1:0] div_cnt;
  logic                  wrap;

  assign wrap = (div_cnt == TICK_DIV_W'(CLKS_PER_TICK - 1));

  // Free running divider, one tick per CLKS_PER_TICK cycles
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else begin
      tick <= wrap;
      if (wrap) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule

// File: design/feature_fifo.sv
`timescale 1ns/100ps

module feature_fifo (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  ble_pkg::feature_beat_t in_beat,
  input  logic                   in_valid,
  output logic                   in_ready,
  output ble_pkg::feature_beat_t out_beat,
  output logic                   out_valid,
  input  logic                   out_ready
);
  import ble_pkg::*;

  feature_beat_t           mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0]   wr_ptr;
  logic [FIFO_PTR_W-1:0]   rd_ptr;
  logic [FIFO_PTR_W:0]     count;
  logic [FIFO_PTR_W:0]     count_next;
  logic                    push;
  logic                    pop;

  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;
  assign out_valid = (count != '0);
  assign out_beat  = mem[rd_ptr];

  always_comb begin
    case ({push, pop})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b0;
    end else begin
      count    <= count_next;
      // Registered full flag, low only while every entry is taken
      in_ready <= (count_next != (FIFO_PTR_W + 1)'(FIFO_DEPTH));
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_in) begin
    if (push) begin
      mem[wr_ptr] <= in_beat;
    end
  end

endmodule

// File: design/frame_sender.sv
`timescale 1ns/100ps

module frame_sender (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   write_enable_in,
  input  ble_pkg::feature_beat_t beat,
  input  logic                   beat_valid,
  output logic                   beat_ready,
  output ble_pkg::uart_byte_t    tx_byte,
  output logic                   tx_load,
  input  logic                   tx_idle,
  input  logic                   tx_done
);
  import ble_pkg::*;

  tx_state_t     state;
  feature_beat_t cur_beat;
  logic          in_frame;
  logic          frame_en;
  logic          word_en;
  logic          take;

  // First word of a frame uses the live enable, later words the latched one
  assign word_en = in_frame ? frame_en : write_enable_in;

  always_comb begin
    case (state)
      IDLE:    beat_ready = tx_idle;
      DROP:    beat_ready = 1'b1;
      default: beat_ready = 1'b0;
    endcase
  end

  assign take = beat_valid & beat_ready;

  ////////////////////////////////////////////////////////////////////////
  // Frame tracking
  ////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      in_frame <= 1'b0;
      frame_en <= 1'b0;
    end else if (take) begin
      in_frame <= !beat.last;
      if (!in_frame) begin
        frame_en <= write_enable_in;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Byte sequencing
  ////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state   <= IDLE;
      tx_load <= 1'b0;
    end else begin
      tx_load <= 1'b0;
      case (state)
        IDLE: begin
          if (take) begin
            if (word_en) begin
              tx_load <= 1'b1;
              state   <= LOW_BYTE;
            end else if (!beat.last) begin
              state <= DROP;
            end
          end
        end
        LOW_BYTE: begin
          if (tx_done) begin
            tx_load <= 1'b1;
            state   <= HIGH_BYTE;
          end
        end
        HIGH_BYTE: begin
          if (tx_done) begin
            if (cur_beat.last) begin
              tx_load <= 1'b1;
              state   <= FLUSH;
            end else begin
              state <= IDLE;
            end
          end
        end
        FLUSH: begin
          if (tx_done) begin
            state <= IDLE;
          end
        end
        DROP: begin
          // Rest of a disabled frame, one word per cycle
          if (take && beat.last) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Byte to the serializer, low half first
  always_ff @(posedge clk_in) begin
    if (state == IDLE && take) begin
      cur_beat <= beat;
      tx_byte  <= beat.data[7:0];
    end else if (state == LOW_BYTE && tx_done) begin
      tx_byte <= cur_beat.data[15:8];
    end else if (state == HIGH_BYTE && tx_done) begin
      tx_byte <= FLUSH_BYTE;
    end
  end

endmodule

// File: design/uart_tx.sv
`timescale 1ns/100ps

module uart_tx (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                tick,
  input  ble_pkg::uart_byte_t data,
  input  logic                load,
  output logic                tx,
  output logic                idle,
  output logic                done
);
  import ble_pkg::*;

  logic [UART_FRAME_BITS-1:0] shreg;
  logic [TICK_CNT_W-1:0]      tick_cnt;
  logic [BIT_CNT_W-1:0]       bit_cnt;
  logic                       busy;
  logic                       bit_end;

  // Line follows the low end of the shift register, ones shift in behind
  assign tx      = shreg[0];
  assign idle    = !busy;
  assign bit_end = tick && (tick_cnt == TICK_CNT_W'(SAMPLE_RATE - 1));

  ////////////////////////////////////////////////////////////////////////
  // 8N1 serializer
  ////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      shreg    <= '1;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      busy     <= 1'b0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (load) begin
          // Stop bit, data LSB first, start bit
          shreg    <= {1'b1, data, 1'b0};
          tick_cnt <= '0;
          bit_cnt  <= '0;
          busy     <= 1'b1;
        end
      end else if (tick) begin
        if (bit_end) begin
          tick_cnt <= '0;
          if (bit_cnt == BIT_CNT_W'(UART_FRAME_BITS - 1)) begin
            // End of stop bit
            busy <= 1'b0;
            done <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
            shreg   <= {1'b1, shreg[UART_FRAME_BITS-1:1]};
          end
        end else begin
          tick_cnt <= tick_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// File: design/uart_rx.sv
`timescale 1ns/100ps

module uart_rx (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                tick,
  input  logic                rx,
  output ble_pkg::uart_byte_t data,
  output logic                valid
);
  import ble_pkg::*;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t             state;
  logic                  rx_meta;
  logic                  rx_sync;
  logic [TICK_CNT_W-1:0] tick_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  uart_byte_t            shreg;

  // Two flop synchronizer, idles high like the line
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Oversampling receiver
  ////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state    <= RX_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      valid    <= 1'b0;
    end else begin
      valid <= 1'b0;
      if (tick) begin
        tick_cnt <= tick_cnt + 1'b1;
        case (state)
          RX_IDLE: begin
            tick_cnt <= '0;
            if (!rx_sync) begin
              state <= RX_START;
            end
          end
          RX_START: begin
            // Start bit must still be low at its centre
            if (tick_cnt == TICK_CNT_W'(SAMPLE_RATE / 2 - 1)) begin
              tick_cnt <= '0;
              bit_cnt  <= '0;
              state    <= rx_sync ? RX_IDLE : RX_DATA;
            end
          end
          RX_DATA: begin
            if (tick_cnt == TICK_CNT_W'(SAMPLE_RATE - 1)) begin
              tick_cnt <= '0;
              shreg    <= {rx_sync, shreg[UART_DATA_BITS-1:1]};
              bit_cnt  <= bit_cnt + 1'b1;
              if (bit_cnt == BIT_CNT_W'(UART_DATA_BITS - 1)) begin
                state <= RX_STOP;
              end
            end
          end
          RX_STOP: begin
            if (tick_cnt == TICK_CNT_W'(SAMPLE_RATE - 1)) begin
              tick_cnt <= '0;
              state    <= RX_IDLE;
              // Framing error drops the byte
              valid    <= rx_sync;
            end
          end
          default: state <= RX_IDLE;
        endcase
      end
    end
  end

  // Received byte, held until the next stop bit
  always_ff @(posedge clk_in) begin
    if (tick && state == RX_STOP && tick_cnt == TICK_CNT_W'(SAMPLE_RATE - 1)) begin
      data <= shreg;
    end
  end

endmodule

// File: design/param_assembler.sv
`timescale 1ns/100ps

module param_assembler (
  input  logic                 clk_in,
  input  logic                 rst_in,
  input  ble_pkg::uart_byte_t  byte_in,
  input  logic                 byte_valid,
  output ble_pkg::param_word_t word,
  output logic                 word_valid
);
  import ble_pkg::*;

  uart_byte_t high_byte;
  logic       phase;

  ////////////////////////////////////////////////////////////////////////
  // Byte pairing, high half arrives first
  ////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      phase      <= 1'b0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (byte_valid) begin
        phase <= !phase;
        if (phase) begin
          word_valid <= 1'b1;
        end
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk_in) begin
    if (byte_valid) begin
      if (!phase) begin
        high_byte <= byte_in;
      end else begin
        word <= {high_byte, byte_in};
      end
    end
  end

endmodule

// File: design/ble_link.sv
`timescale 1ns/100ps

module ble_link (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   write_enable_in,
  input  ble_pkg::feature_beat_t feature_in,
  input  logic                   feature_valid_in,
  output logic                   feature_ready,
  input  logic                   uart_rx_in,
  output logic                   uart_tx,
  output ble_pkg::param_word_t   param_word,
  output logic                   param_valid
);
  import ble_pkg::*;

  logic          tick;
  feature_beat_t fifo_beat;
  logic          fifo_valid;
  logic          fifo_ready;
  uart_byte_t    tx_byte;
  logic          tx_load;
  logic          tx_idle;
  logic          tx_done;
  uart_byte_t    rx_byte;
  logic          rx_valid;

  // Shared by both directions
  baud_tick_gen u_tick (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .tick   (tick)
  );

  ////////////////////////////////////////////////////////////////////////
  // Transmit path
  ////////////////////////////////////////////////////////////////////////
  feature_fifo u_fifo (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .in_beat   (feature_in),
    .in_valid  (feature_valid_in),
    .in_ready  (feature_ready),
    .out_beat  (fifo_beat),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready)
  );

  frame_sender u_sender (
    .clk_in          (clk_in),
    .rst_in          (rst_in),
    .write_enable_in (write_enable_in),
    .beat            (fifo_beat),
    .beat_valid      (fifo_valid),
    .beat_ready      (fifo_ready),
    .tx_byte         (tx_byte),
    .tx_load         (tx_load),
    .tx_idle         (tx_idle),
    .tx_done         (tx_done)
  );

  uart_tx u_uart_tx (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .tick   (tick),
    .data   (tx_byte),
    .load   (tx_load),
    .tx     (uart_tx),
    .idle   (tx_idle),
    .done   (tx_done)
  );

  ////////////////////////////////////////////////////////////////////////
  // Receive path
  ////////////////////////////////////////////////////////////////////////
  uart_rx u_uart_rx (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .tick   (tick),
    .rx     (uart_rx_in),
    .data   (rx_byte),
    .valid  (rx_valid)
  );

  param_assembler u_params (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .byte_in    (rx_byte),
    .byte_valid (rx_valid),
    .word       (param_word),
    .word_valid (param_valid)
  );

endmodule

// File: verif/ble_link_tb.sv
`timescale 1ns/100ps

module ble_link_tb;
  import ble_pkg::*;

  localparam int BIT_CYCLES    = SAMPLE_RATE * CLKS_PER_TICK;
  localparam int FRAME_CYCLES  = BIT_CYCLES * UART_FRAME_BITS;
  localparam int MARGIN_CYCLES = 2000;
  localparam int BURST_WORDS   = FIFO_DEPTH + 6;

  logic          clk_in;
  logic          rst_in;
  logic          write_enable_in;
  feature_beat_t feature_in;
  logic          feature_valid_in;
  logic          feature_ready;
  logic          uart_rx_in;
  logic          uart_tx;
  param_word_t   param_word;
  logic          param_valid;

  int            seed;
  string         test_name;
  int            cycle_cnt;
  int            limit_cycles = 0;
  logic          ready_dropped;
  logic          ref_phase;
  uart_byte_t    ref_high;

  feature_word_t frame_words[$];
  uart_byte_t    exp_bytes[$];
  uart_byte_t    act_bytes[$];
  uart_byte_t    sent_bytes[$];
  logic          sent_bad[$];
  param_word_t   exp_params[$];
  param_word_t   act_params[$];

  ble_link UUT (
    .clk_in           (clk_in),
    .rst_in           (rst_in),
    .write_enable_in  (write_enable_in),
    .feature_in       (feature_in),
    .feature_valid_in (feature_valid_in),
    .feature_ready    (feature_ready),
    .uart_rx_in       (uart_rx_in),
    .uart_tx          (uart_tx),
    .param_word       (param_word),
    .param_valid      (param_valid)
  );

  always #2 clk_in = ~clk_in;

  ////////////////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  ////////////////////////////////////////////////////////////////////////
  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_byte(string name, uart_byte_t exp, uart_byte_t act);
    if (exp !== act) begin
      report_failure($sformatf("[ERROR] %s: expected 0x%02h, actual 0x%02h", name, exp, act));
    end
  endtask

  task automatic check_param(string name, param_word_t exp, param_word_t act);
    if (exp !== act) begin
      report_failure($sformatf("[ERROR] %s: expected 0x%04h, actual 0x%04h", name, exp, act));
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (exp !== act) begin
      report_failure($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////

  // Low byte then high byte per word, newline closes an enabled frame
  function automatic void expect_frame(logic enabled);
    if (enabled) begin
      foreach (frame_words[i]) begin
        exp_bytes.push_back(frame_words[i][7:0]);
        exp_bytes.push_back(frame_words[i][15:8]);
      end
      exp_bytes.push_back(FLUSH_BYTE);
    end
  endfunction

  // Good bytes pair up high half first, phase carries over between tests
  function automatic void expect_params();
    foreach (sent_bytes[i]) begin
      if (!sent_bad[i]) begin
        if (ref_phase) begin
          exp_params.push_back({ref_high, sent_bytes[i]});
        end else begin
          ref_high = sent_bytes[i];
        end
        ref_phase = !ref_phase;
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // Stimulus helpers, all called at a falling edge
  ////////////////////////////////////////////////////////////////////////
  task automatic make_frame(int len);
    frame_words.delete();
    repeat (len) begin
      frame_words.push_back(feature_word_t'($random(seed)));
    end
  endtask

  task automatic push_beat(feature_word_t data, logic last);
    logic taken;
    feature_in.data  = data;
    feature_in.last  = last;
    feature_valid_in = 1'b1;
    taken            = 1'b0;
    while (!taken) begin
      // Ready is registered, so its value now holds through the next rising edge
      taken = feature_ready;
      if (!taken) begin
        ready_dropped = 1'b1;
      end
      @(negedge clk_in);
    end
  endtask

  task automatic send_frame(int raise_enable_at);
    foreach (frame_words[i]) begin
      if (i == raise_enable_at) begin
        feature_valid_in = 1'b0;
        repeat (4) @(negedge clk_in);
        write_enable_in = 1'b1;
      end
      push_beat(frame_words[i], (i == frame_words.size() - 1));
    end
    feature_valid_in = 1'b0;
  endtask

  task automatic send_rx_byte(uart_byte_t value, logic bad_stop);
    uart_rx_in = 1'b0;
    repeat (BIT_CYCLES) @(negedge clk_in);
    for (int i = 0; i < UART_DATA_BITS; i++) begin
      uart_rx_in = value[i];
      repeat (BIT_CYCLES) @(negedge clk_in);
    end
    if (bad_stop) begin
      // Low past the bit centre, high again before a false start qualifies
      uart_rx_in = 1'b0;
      repeat (BIT_CYCLES * 3 / 4) @(negedge clk_in);
      uart_rx_in = 1'b1;
      repeat (BIT_CYCLES / 4) @(negedge clk_in);
    end else begin
      uart_rx_in = 1'b1;
      repeat (BIT_CYCLES) @(negedge clk_in);
    end
    // One idle bit between bytes
    repeat (BIT_CYCLES) @(negedge clk_in);
  endtask

  task automatic drive_sent();
    foreach (sent_bytes[i]) begin
      send_rx_byte(sent_bytes[i], sent_bad[i]);
    end
    sent_bytes.delete();
    sent_bad.delete();
  endtask

  task automatic wait_drained();
    while (exp_bytes.size() != 0 || act_bytes.size() != 0 ||
           exp_params.size() != 0 || act_params.size() != 0) begin
      @(negedge clk_in);
    end
    // Lets the last stop bit finish and exposes any stray output
    repeat (BIT_CYCLES) @(negedge clk_in);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Monitors, compare and watchdog
  ////////////////////////////////////////////////////////////////////////
  initial begin : tx_monitor
    uart_byte_t value;
    forever begin
      @(negedge clk_in);
      if (!rst_in && uart_tx === 1'b0) begin
        repeat (BIT_CYCLES / 2) @(negedge clk_in);
        if (uart_tx !== 1'b0) begin
          report_failure("Start bit on uart_tx did not hold to its centre");
        end
        for (int i = 0; i < UART_DATA_BITS; i++) begin
          repeat (BIT_CYCLES) @(negedge clk_in);
          value[i] = uart_tx;
        end
        repeat (BIT_CYCLES) @(negedge clk_in);
        if (uart_tx !== 1'b1) begin
          report_failure("Stop bit on uart_tx was low");
        end
        act_bytes.push_back(value);
      end
    end
  end

  always @(negedge clk_in) begin
    if (!rst_in && param_valid === 1'b1) begin
      act_params.push_back(param_word);
    end
  end

  initial begin : compare
    forever begin
      @(negedge clk_in);
      while (act_bytes.size() > 0) begin
        if (exp_bytes.size() == 0) begin
          report_failure($sformatf("Unexpected byte 0x%02h on uart_tx in %s",
                                   act_bytes[0], test_name));
        end
        check_byte(test_name, exp_bytes.pop_front(), act_bytes.pop_front());
      end
      while (act_params.size() > 0) begin
        if (exp_params.size() == 0) begin
          report_failure($sformatf("Unexpected parameter word 0x%04h in %s",
                                   act_params[0], test_name));
        end
        check_param(test_name, exp_params.pop_front(), act_params.pop_front());
      end
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    wait (limit_cycles > 0);
    while (cycle_cnt < limit_cycles) begin
      @(posedge clk_in);
      cycle_cnt++;
    end
    report_failure($sformatf("Timeout, run did not finish within %0d cycles", limit_cycles));
  end

  ////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////
  initial begin : stimulus
    int len_enabled;
    int len_disabled;
    int tx_total;
    int rx_total;
    clk_in           = 1'b0;
    rst_in           = 1'b1;
    write_enable_in  = 1'b1;
    feature_in       = '0;
    feature_valid_in = 1'b0;
    uart_rx_in       = 1'b1;
    ready_dropped    = 1'b0;
    ref_phase        = 1'b0;
    ref_high         = '0;
    test_name        = "reset";
    seed             = 32'hd66e_dfb6;

    len_enabled  = 3 + int'($unsigned($random(seed)) % 4);
    len_disabled = 3 + int'($unsigned($random(seed)) % 3);
    tx_total     = (2 * len_enabled + 1) + (2 * 2 + 1) + (2 * BURST_WORDS + 1);
    rx_total     = 6 + 5;
    limit_cycles = (tx_total + rx_total) * FRAME_CYCLES + MARGIN_CYCLES;

    repeat (10) @(negedge clk_in);
    rst_in = 1'b0;

    // Idle levels right after reset
    test_name = "reset_idle";
    repeat (40) begin
      @(negedge clk_in);
      check_flag({test_name, "/uart_tx"}, 1'b1, uart_tx);
      check_flag({test_name, "/param_valid"}, 1'b0, param_valid);
      check_flag({test_name, "/feature_ready"}, 1'b1, feature_ready);
    end

    test_name = "enabled_frame";
    make_frame(len_enabled);
    expect_frame(1'b1);
    send_frame(-1);
    wait_drained();

    // Enable rises after the first word has gone, frame stays dropped
    test_name       = "disabled_frame";
    write_enable_in = 1'b0;
    make_frame(len_disabled);
    expect_frame(1'b0);
    send_frame(1);
    make_frame(2);
    expect_frame(1'b1);
    send_frame(-1);
    wait_drained();

    test_name     = "fifo_burst";
    ready_dropped = 1'b0;
    make_frame(BURST_WORDS);
    expect_frame(1'b1);
    send_frame(-1);
    wait_drained();
    check_flag({test_name, "/ready_dropped"}, 1'b1, ready_dropped);

    test_name = "param_pairs";
    repeat (6) begin
      sent_bytes.push_back(uart_byte_t'($random(seed)));
      sent_bad.push_back(1'b0);
    end
    expect_params();
    drive_sent();
    wait_drained();

    // Second byte has a low stop bit
    test_name = "bad_stop_bit";
    for (int i = 0; i < 5; i++) begin
      sent_bytes.push_back(uart_byte_t'($random(seed)));
      sent_bad.push_back(i == 1);
    end
    expect_params();
    drive_sent();
    wait_drained();

    if (exp_bytes.size() == 0 && act_bytes.size() == 0 &&
        exp_params.size() == 0 && act_params.size() == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      report_failure("Output queues not empty at the end of the run");
    end
  end

endmodule

// File: files.f
design/ble_pkg.sv
design/baud_tick_gen.sv
design/feature_fifo.sv
design/frame_sender.sv
design/uart_tx.sv
design/uart_rx.sv
design/param_assembler.sv
design/ble_link.sv
verif/ble_link_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module ble_link_tb -Mdir obj_dir -f files.f || exit 1
sim_out="$(./obj_dir/Vble_link_tb 2>&1)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qF "=== PASS ===" && exit 0 || exit 1
